//--- Makefile
TOP := tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module cpu \
		src/isa_pkg.sv src/mem_bus_pkg.sv src/alu.sv src/register_file.sv \
		src/control_unit.sv src/memory_access.sv src/cpu.sv

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- sim.f
src/isa_pkg.sv
src/mem_bus_pkg.sv
src/alu.sv
src/register_file.sv
src/control_unit.sv
src/memory_access.sv
src/cpu.sv
verif/tb_memory.sv
verif/tb_cpu.sv

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire logic [isa_pkg::WORD_SIZE-1:0] a,
	input  wire logic [isa_pkg::WORD_SIZE-1:0] b,
	input  wire isa_pkg::alu_op_t              op,
	output logic [isa_pkg::WORD_SIZE-1:0]      result,
	output logic                               zero
);
	import isa_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			// unary ops work on a only
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + WORD_SIZE'(1);
			ALU_SHL: result = {a[WORD_SIZE-2:0], 1'b0};
			// arithmetic shift keeps the sign bit
			ALU_SHR: result = {a[WORD_SIZE-1], a[WORD_SIZE-1:1]};
			ALU_PASS_B: result = b;
			default: result = '0;
		endcase
	end

	// branches read this after SUB
	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  wire logic [isa_pkg::WORD_SIZE-1:0] instr,
	output isa_pkg::ctrl_t                     ctrl
);
	import isa_pkg::*;

	opcode_t opcode;
	func_t   func;

	assign opcode = opcode_t'(instr[OPCODE_HI:OPCODE_LO]);
	assign func = func_t'(instr[FUNC_HI:FUNC_LO]);

	always_comb begin
		// nop unless decoded below
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		ctrl.imm_kind = IMM_SIGN;
		ctrl.dest_sel = DEST_RD;
		ctrl.pc_sel = PC_SEQ;

		case (opcode)
			OP_RTYPE: begin
				case (func)
					FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
						ctrl.reg_write = 1'b1;
						case (func)
							FN_SUB:  ctrl.alu_op = ALU_SUB;
							FN_AND:  ctrl.alu_op = ALU_AND;
							FN_ORR:  ctrl.alu_op = ALU_OR;
							FN_NOT:  ctrl.alu_op = ALU_NOT;
							FN_TCP:  ctrl.alu_op = ALU_TCP;
							FN_SHL:  ctrl.alu_op = ALU_SHL;
							FN_SHR:  ctrl.alu_op = ALU_SHR;
							default: ctrl.alu_op = ALU_ADD;
						endcase
					end
					FN_JPR: ctrl.pc_sel = PC_REG;
					FN_JRL: begin
						ctrl.pc_sel = PC_REG;
						ctrl.reg_write = 1'b1;
						ctrl.dest_sel = DEST_LINK;
						ctrl.pc_to_reg = 1'b1;
					end
					FN_HLT: ctrl.halt = 1'b1;
					default: ;
				endcase
			end
			OP_ADI, OP_ORI, OP_LHI: begin
				ctrl.alu_src = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel = DEST_RT;
				if (opcode == OP_ORI) begin
					ctrl.alu_op = ALU_OR;
					ctrl.imm_kind = IMM_ZERO;
				end else if (opcode == OP_LHI) begin
					ctrl.alu_op = ALU_PASS_B;
					ctrl.imm_kind = IMM_UPPER;
				end
			end
			OP_LWD: begin
				ctrl.alu_src = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel = DEST_RT;
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			OP_SWD: begin
				ctrl.alu_src = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			// compare rs with rt through the alu zero flag
			OP_BNE, OP_BEQ: begin
				ctrl.alu_op = ALU_SUB;
				ctrl.pc_sel = PC_BRANCH;
				ctrl.branch_on_equal = (opcode == OP_BEQ);
			end
			OP_JMP: ctrl.pc_sel = PC_TARGET;
			OP_JAL: begin
				ctrl.pc_sel = PC_TARGET;
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel = DEST_LINK;
				ctrl.pc_to_reg = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- src/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input  wire logic                          clk,
	input  wire logic                          reset,
	output logic                               read_m,
	output logic                               write_m,
	output logic [isa_pkg::WORD_SIZE-1:0]      address,
	output logic [isa_pkg::WORD_SIZE-1:0]      data_out,
	input  wire logic [isa_pkg::WORD_SIZE-1:0] data_in,
	input  wire logic                          input_ready,
	input  wire logic                          ack_output,
	output logic                               halted
);
	import isa_pkg::*;
	import mem_bus_pkg::*;

	logic [WORD_SIZE-1:0] instr;
	logic [WORD_SIZE-1:0] load_data;
	ctrl_t ctrl;
	mem_req_t req;

	logic [WORD_SIZE-1:0] pc;
	logic [WORD_SIZE-1:0] pc_plus_one;
	logic [WORD_SIZE-1:0] branch_target;
	logic [WORD_SIZE-1:0] pc_next;
	logic fetch_done;
	logic load_done;
	logic wb_strobe;

	logic [WORD_SIZE-1:0] read_data1;
	logic [WORD_SIZE-1:0] read_data2;
	logic [IMM_W-1:0] imm_field;
	logic [WORD_SIZE-1:0] immediate;
	logic [WORD_SIZE-1:0] alu_b;
	logic [WORD_SIZE-1:0] alu_result;
	logic zero;
	logic branch_taken;
	logic [REG_ADDR_W-1:0] write_addr;
	logic [WORD_SIZE-1:0] write_data;

	// instruction and load data share data_in
	always_ff @(posedge clk) begin
		if (fetch_done) begin
			instr <= data_in;
		end
		if (load_done) begin
			load_data <= data_in;
		end
	end

	assign imm_field = instr[IMM_HI:IMM_LO];

	always_comb begin
		case (ctrl.imm_kind)
			IMM_ZERO: immediate = {{(WORD_SIZE-IMM_W){1'b0}}, imm_field};
			IMM_UPPER: immediate = {imm_field, {(WORD_SIZE-IMM_W){1'b0}}};
			default: immediate = {{(WORD_SIZE-IMM_W){imm_field[IMM_W-1]}}, imm_field};
		endcase
	end

	assign alu_b = ctrl.alu_src ? immediate : read_data2;

	always_comb begin
		case (ctrl.dest_sel)
			DEST_RT: write_addr = instr[RT_HI:RT_LO];
			DEST_LINK: write_addr = LINK_REG;
			default: write_addr = instr[RD_HI:RD_LO];
		endcase
	end

	// link stores the return address pc + 1
	assign write_data = ctrl.mem_to_reg ? load_data :
		(ctrl.pc_to_reg ? pc_plus_one : alu_result);

	// pc holds the current instruction until writeback
	assign pc_plus_one = pc + WORD_SIZE'(1);
	assign branch_target = pc_plus_one + immediate;
	assign branch_taken = ctrl.branch_on_equal ? zero : !zero;

	always_comb begin
		case (ctrl.pc_sel)
			PC_BRANCH: pc_next = branch_taken ? branch_target : pc_plus_one;
			PC_TARGET: pc_next = {pc[WORD_SIZE-1:TARGET_HI+1], instr[TARGET_HI:TARGET_LO]};
			PC_REG: pc_next = read_data1;
			default: pc_next = pc_plus_one;
		endcase
	end

	memory_access i_memory_access (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.alu_result(alu_result),
		.store_data(read_data2),
		.pc_next_in(pc_next),
		.input_ready(input_ready),
		.ack_output(ack_output),
		.req(req),
		.pc(pc),
		.fetch_done(fetch_done),
		.load_done(load_done),
		.wb_strobe(wb_strobe),
		.halted(halted)
	);

	control_unit i_control_unit (
		.instr(instr),
		.ctrl(ctrl)
	);

	register_file i_register_file (
		.clk(clk),
		.reset(reset),
		.read_addr1(instr[RS_HI:RS_LO]),
		.read_addr2(instr[RT_HI:RT_LO]),
		.read_data1(read_data1),
		.read_data2(read_data2),
		.write_addr(write_addr),
		.write_data(write_data),
		.write_en(wb_strobe)
	);

	alu i_alu (
		.a(read_data1),
		.b(alu_b),
		.op(ctrl.alu_op),
		.result(alu_result),
		.zero(zero)
	);

	// bus request out to the pins
	assign read_m = req.read_m;
	assign write_m = req.write_m;
	assign address = req.address;
	assign data_out = req.wdata;

endmodule

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int WORD_SIZE = 16;
	localparam int NUM_REGS = 4;
	localparam int REG_ADDR_W = $clog2(NUM_REGS);

	// instruction field positions
	localparam int OPCODE_HI = 15;
	localparam int OPCODE_LO = 12;
	localparam int RS_HI = 11;
	localparam int RS_LO = 10;
	localparam int RT_HI = 9;
	localparam int RT_LO = 8;
	localparam int RD_HI = 7;
	localparam int RD_LO = 6;
	localparam int FUNC_HI = 5;
	localparam int FUNC_LO = 0;
	localparam int IMM_HI = 7;
	localparam int IMM_LO = 0;
	localparam int IMM_W = IMM_HI - IMM_LO + 1;
	localparam int TARGET_HI = 11;
	localparam int TARGET_LO = 0;

	// JAL and JRL write the return address here
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 2'd2;

	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_JAL   = 4'd10,
		OP_RTYPE = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_JPR = 6'd25,
		FN_JRL = 6'd26,
		FN_HLT = 6'd29
	} func_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR, ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} dest_sel_t;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_TARGET, PC_REG} pc_sel_t;

	// upper means imm placed in the high byte
	typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_UPPER} imm_kind_t;

	typedef struct packed {
		logic      alu_src;
		alu_op_t   alu_op;
		imm_kind_t imm_kind;
		logic      reg_write;
		dest_sel_t dest_sel;
		logic      mem_read;
		logic      mem_write;
		logic      mem_to_reg;
		logic      pc_to_reg;
		pc_sel_t   pc_sel;
		logic      branch_on_equal;
		logic      halt;
	} ctrl_t;

endpackage

`default_nettype wire

//--- src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	// one request on the shared fetch/data bus
	typedef struct packed {
		logic                           read_m;
		logic                           write_m;
		logic [isa_pkg::WORD_SIZE-1:0]  address;
		logic [isa_pkg::WORD_SIZE-1:0]  wdata;
	} mem_req_t;

	// multicycle sequencer with one instruction in flight
	typedef enum logic [2:0] {
		FETCH,
		EXECUTE,
		MEM_READ,
		MEM_WRITE,
		WRITEBACK,
		HALTED
	} seq_state_t;

	// first fetch address
	localparam logic [isa_pkg::WORD_SIZE-1:0] RESET_PC = '0;

endpackage

`default_nettype wire

//--- src/memory_access.sv
`timescale 1ns/1ps
`default_nettype none

module memory_access (
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire isa_pkg::ctrl_t                ctrl,
	input  wire logic [isa_pkg::WORD_SIZE-1:0] alu_result,
	input  wire logic [isa_pkg::WORD_SIZE-1:0] store_data,
	input  wire logic [isa_pkg::WORD_SIZE-1:0] pc_next_in,
	input  wire logic                          input_ready,
	input  wire logic                          ack_output,
	output mem_bus_pkg::mem_req_t              req,
	output logic [isa_pkg::WORD_SIZE-1:0]      pc,
	output logic                               fetch_done,
	output logic                               load_done,
	output logic                               wb_strobe,
	output logic                               halted
);
	import mem_bus_pkg::*;

	seq_state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH;
			pc <= RESET_PC;
			req.read_m <= 1'b0;
			req.write_m <= 1'b0;
		end else begin
			case (state)
				FETCH: begin
					if (!req.read_m) begin
						// only reached in the first cycle out of reset
						req.read_m <= 1'b1;
						req.address <= pc;
					end else if (input_ready) begin
						req.read_m <= 1'b0;
						state <= EXECUTE;
					end
				end
				EXECUTE: begin
					// address comes from rs + imm
					if (ctrl.mem_read) begin
						req.read_m <= 1'b1;
						req.address <= alu_result;
						state <= MEM_READ;
					end else if (ctrl.mem_write) begin
						req.write_m <= 1'b1;
						req.address <= alu_result;
						req.wdata <= store_data;
						state <= MEM_WRITE;
					end else begin
						state <= WRITEBACK;
					end
				end
				MEM_READ: begin
					if (input_ready) begin
						req.read_m <= 1'b0;
						state <= WRITEBACK;
					end
				end
				MEM_WRITE: begin
					if (ack_output) begin
						req.write_m <= 1'b0;
						state <= WRITEBACK;
					end
				end
				WRITEBACK: begin
					pc <= pc_next_in;
					if (ctrl.halt) begin
						state <= HALTED;
					end else begin
						// next fetch request goes out right away
						req.read_m <= 1'b1;
						req.address <= pc_next_in;
						state <= FETCH;
					end
				end
				HALTED: state <= HALTED;
				default: state <= FETCH;
			endcase
		end
	end

	// one-cycle strobes since input_ready pulses once per request
	assign fetch_done = (state == FETCH) && req.read_m && input_ready;
	assign load_done = (state == MEM_READ) && input_ready;
	assign wb_strobe = (state == WRITEBACK) && ctrl.reg_write;
	assign halted = (state == HALTED);

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire logic                           clk,
	input  wire logic                           reset,
	input  wire logic [isa_pkg::REG_ADDR_W-1:0] read_addr1,
	input  wire logic [isa_pkg::REG_ADDR_W-1:0] read_addr2,
	output logic [isa_pkg::WORD_SIZE-1:0]       read_data1,
	output logic [isa_pkg::WORD_SIZE-1:0]       read_data2,
	input  wire logic [isa_pkg::REG_ADDR_W-1:0] write_addr,
	input  wire logic [isa_pkg::WORD_SIZE-1:0]  write_data,
	input  wire logic                           write_en
);
	import isa_pkg::*;

	logic [WORD_SIZE-1:0] regs [NUM_REGS];

	// read ports see the old value until the write edge
	assign read_data1 = regs[read_addr1];
	assign read_data2 = regs[read_addr2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import isa_pkg::*;

	typedef struct packed {
		logic [WORD_SIZE-1:0] addr;
		logic [WORD_SIZE-1:0] data;
	} store_t;

	logic clk;
	logic reset;
	logic read_m;
	logic write_m;
	logic [WORD_SIZE-1:0] address;
	logic [WORD_SIZE-1:0] data_out;
	logic [WORD_SIZE-1:0] data_in;
	logic input_ready;
	logic ack_output;
	logic halted;

	logic [WORD_SIZE-1:0] image [256];
	logic [WORD_SIZE-1:0] exp_reads [$];
	store_t exp_stores [$];
	int read_count;
	int write_count;
	logic read_answered;
	logic write_answered;

	cpu i_dut (
		.clk(clk),
		.reset(reset),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.data_out(data_out),
		.data_in(data_in),
		.input_ready(input_ready),
		.ack_output(ack_output),
		.halted(halted)
	);

	tb_memory i_memory (
		.clk(clk),
		.reset(reset),
		.image(image),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.data_out(data_out),
		.data_in(data_in),
		.input_ready(input_ready),
		.ack_output(ack_output)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50;
			clk = ~clk;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation aborted");
	endtask

	task automatic check_value(input string name, input logic [WORD_SIZE-1:0] expected,
			input logic [WORD_SIZE-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual));
		end
	endtask

	function automatic logic [WORD_SIZE-1:0] itype_word(opcode_t op, int rs, int rt,
			logic [7:0] imm);
		return {op, 2'(rs), 2'(rt), imm};
	endfunction

	function automatic logic [WORD_SIZE-1:0] rtype_word(int rs, int rt, int rd, func_t fn);
		return {OP_RTYPE, 2'(rs), 2'(rt), 2'(rd), fn};
	endfunction

	function automatic logic [WORD_SIZE-1:0] jtype_word(opcode_t op, logic [11:0] target);
		return {op, target};
	endfunction

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			image[i] = {~i[7:0], i[7:0]};
		end
		image[8'hC0] = 16'hBEEF;
		// r3 holds the data base and r1 and r2 hold the operands
		image[0] = itype_word(OP_ORI, 0, 3, 8'hC0);
		image[1] = itype_word(OP_LHI, 0, 1, 8'h12);
		image[2] = itype_word(OP_ORI, 1, 1, 8'h34);
		image[3] = itype_word(OP_ADI, 0, 2, 8'hFB);
		image[4] = rtype_word(1, 2, 0, FN_ADD);
		image[5] = itype_word(OP_SWD, 3, 0, 8'h10);
		image[6] = rtype_word(1, 2, 0, FN_SUB);
		image[7] = itype_word(OP_SWD, 3, 0, 8'h11);
		image[8] = rtype_word(1, 2, 0, FN_AND);
		image[9] = itype_word(OP_SWD, 3, 0, 8'h12);
		image[10] = rtype_word(1, 2, 0, FN_ORR);
		image[11] = itype_word(OP_SWD, 3, 0, 8'h13);
		image[12] = rtype_word(1, 0, 0, FN_NOT);
		image[13] = itype_word(OP_SWD, 3, 0, 8'h14);
		image[14] = rtype_word(2, 0, 0, FN_TCP);
		image[15] = itype_word(OP_SWD, 3, 0, 8'h15);
		image[16] = rtype_word(1, 0, 0, FN_SHL);
		image[17] = itype_word(OP_SWD, 3, 0, 8'h16);
		image[18] = rtype_word(2, 0, 0, FN_SHR);
		image[19] = itype_word(OP_SWD, 3, 0, 8'h17);
		image[20] = itype_word(OP_SWD, 3, 1, 8'h18);
		image[21] = itype_word(OP_SWD, 3, 2, 8'h19);
		// copy the data word to a new address
		image[22] = itype_word(OP_LWD, 3, 0, 8'h00);
		image[23] = itype_word(OP_SWD, 3, 0, 8'h1A);
		// untaken, taken, taken, untaken
		image[24] = itype_word(OP_BEQ, 1, 2, 8'd5);
		image[25] = itype_word(OP_BNE, 1, 2, 8'd1);
		image[27] = itype_word(OP_BEQ, 1, 1, 8'd1);
		image[29] = itype_word(OP_BNE, 2, 2, 8'd3);
		image[30] = jtype_word(OP_JAL, 12'd34);
		image[31] = itype_word(OP_SWD, 3, 2, 8'h1B);
		image[32] = jtype_word(OP_JMP, 12'd36);
		image[34] = rtype_word(2, 0, 0, FN_JPR);
		image[36] = itype_word(OP_ADI, 2, 1, 8'd9);
		image[37] = rtype_word(1, 0, 0, FN_JRL);
		image[40] = itype_word(OP_SWD, 3, 2, 8'h1C);
		image[41] = rtype_word(0, 0, 0, FN_HLT);
	endtask

	// ISA model that returns 1 once HLT is reached
	function automatic bit run_model();
		logic [WORD_SIZE-1:0] mem [256];
		logic [WORD_SIZE-1:0] regs [NUM_REGS];
		logic [WORD_SIZE-1:0] pc;
		logic [WORD_SIZE-1:0] pc_next;
		logic [WORD_SIZE-1:0] ins;
		logic [WORD_SIZE-1:0] a;
		logic [WORD_SIZE-1:0] b;
		logic [WORD_SIZE-1:0] simm;
		logic [WORD_SIZE-1:0] ea;
		logic [1:0] rt;
		logic [1:0] rd;
		mem = image;
		pc = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			regs[i] = '0;
		end
		for (int step = 0; step < 1000; step++) begin
			exp_reads.push_back(pc);
			ins = mem[pc[7:0]];
			a = regs[ins[RS_HI:RS_LO]];
			b = regs[ins[RT_HI:RT_LO]];
			rt = ins[RT_HI:RT_LO];
			rd = ins[RD_HI:RD_LO];
			simm = {{8{ins[7]}}, ins[7:0]};
			ea = a + simm;
			pc_next = pc + 16'd1;
			case (ins[15:12])
				OP_ADI: regs[rt] = a + simm;
				OP_ORI: regs[rt] = a | {8'h00, ins[7:0]};
				OP_LHI: regs[rt] = {ins[7:0], 8'h00};
				OP_LWD: begin
					exp_reads.push_back(ea);
					regs[rt] = mem[ea[7:0]];
				end
				OP_SWD: begin
					mem[ea[7:0]] = b;
					exp_stores.push_back(store_t'{addr: ea, data: b});
				end
				OP_BNE: if (a != b) pc_next = pc_next + simm;
				OP_BEQ: if (a == b) pc_next = pc_next + simm;
				OP_JMP: pc_next = {pc[15:12], ins[11:0]};
				OP_JAL: begin
					regs[2] = pc_next;
					pc_next = {pc[15:12], ins[11:0]};
				end
				OP_RTYPE: begin
					case (ins[5:0])
						FN_ADD: regs[rd] = a + b;
						FN_SUB: regs[rd] = a - b;
						FN_AND: regs[rd] = a & b;
						FN_ORR: regs[rd] = a | b;
						FN_NOT: regs[rd] = ~a;
						FN_TCP: regs[rd] = -a;
						FN_SHL: regs[rd] = a << 1;
						FN_SHR: regs[rd] = $signed(a) >>> 1;
						FN_JPR: pc_next = a;
						FN_JRL: begin
							regs[2] = pc_next;
							pc_next = a;
						end
						FN_HLT: return 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = pc_next;
		end
		return 1'b0;
	endfunction

	// bus monitor against the model trace
	initial begin
		read_count = 0;
		write_count = 0;
		read_answered = 1'b0;
		write_answered = 1'b0;
		forever begin
			@(negedge clk);
			if (reset) begin
				check_value("read_m", 16'd0, 16'(read_m));
				check_value("write_m", 16'd0, 16'(write_m));
				check_value("halted", 16'd0, 16'(halted));
			end else begin
				if (read_m && write_m) begin
					abort_run("read_m and write_m are high in the same cycle");
				end
				// request drops in the cycle after its answer
				if (read_answered) begin
					check_value("read_m", 16'd0, 16'(read_m));
				end
				if (write_answered) begin
					check_value("write_m", 16'd0, 16'(write_m));
				end
				read_answered = read_m && input_ready;
				write_answered = write_m && ack_output;
				if (read_answered) begin
					if (read_count >= exp_reads.size()) begin
						abort_run("the core read more words than the model did");
					end
					check_value("address", exp_reads[read_count], address);
					read_count++;
				end
				if (write_answered) begin
					if (write_count >= exp_stores.size()) begin
						abort_run("the core stored more words than the model did");
					end
					check_value("address", exp_stores[write_count].addr, address);
					check_value("data_out", exp_stores[write_count].data, data_out);
					write_count++;
				end
			end
		end
	end

	initial begin
		int wait_cycles;
		reset = 1'b1;
		load_program();
		if (!run_model()) begin
			abort_run("the model never reached HLT");
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		wait_cycles = 0;
		while (!halted) begin
			@(negedge clk);
			wait_cycles++;
			if (wait_cycles > 5000) begin
				abort_run("timed out waiting for halted");
			end
		end
		check_value("read count", 16'(exp_reads.size()), 16'(read_count));
		check_value("store count", 16'(exp_stores.size()), 16'(write_count));
		// halted core stays quiet
		repeat (50) begin
			@(negedge clk);
			if (read_m || write_m) begin
				abort_run("a bus request appeared after halt");
			end
			check_value("halted", 16'd1, 16'(halted));
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire logic [isa_pkg::WORD_SIZE-1:0] image [256],
	input  wire logic                          read_m,
	input  wire logic                          write_m,
	input  wire logic [isa_pkg::WORD_SIZE-1:0] address,
	input  wire logic [isa_pkg::WORD_SIZE-1:0] data_out,
	output logic [isa_pkg::WORD_SIZE-1:0]      data_in,
	output logic                               input_ready,
	output logic                               ack_output
);
	import isa_pkg::*;

	logic [WORD_SIZE-1:0] mem [256];
	integer seed;
	int latency;

	initial begin
		seed = 99;
		latency = 0;
		data_in = '0;
		input_ready = 1'b0;
		ack_output = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (reset) begin
				// reload the program image while the core is held
				mem = image;
			end else if (read_m || write_m) begin
				// 0 to 3 extra cycles before the answer
				latency = $random(seed) & 3;
				repeat (latency) begin
					@(posedge clk);
					#1;
				end
				if (read_m) begin
					data_in = mem[address[7:0]];
					input_ready = 1'b1;
				end else begin
					mem[address[7:0]] = data_out;
					ack_output = 1'b1;
				end
				// answer lasts exactly one cycle
				@(posedge clk);
				#1;
				input_ready = 1'b0;
				ack_output = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire
